//--- include/fb_macros.svh
/* framebuffer scaler constants
   raster geometry, framebuffer size, scale limit and APB address map */
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// horizontal raster in pixel clocks
`define FB_H_ACTIVE 32
`define FB_H_FP     2
`define FB_H_SYNC   4
`define FB_H_BP     2
`define FB_H_TOTAL  (`FB_H_ACTIVE + `FB_H_FP + `FB_H_SYNC + `FB_H_BP)

// vertical raster in lines
`define FB_V_ACTIVE 24
`define FB_V_FP     1
`define FB_V_SYNC   2
`define FB_V_BP     1
`define FB_V_TOTAL  (`FB_V_ACTIVE + `FB_V_FP + `FB_V_SYNC + `FB_V_BP)

`define FB_WIDTH     8   // source pixels per row
`define FB_HEIGHT    6   // source rows
`define FB_SCALE_MAX 4
`define FB_CORDW     6   // coordinate bits

// apb byte addresses, word stride
`define FB_ADDR_CTRL 12'h000
`define FB_ADDR_PAL  12'h040
`define FB_ADDR_FB   12'h100

`endif

//--- hw/fb_pkg.sv
/* framebuffer scaler types
   colour, index and scale types plus APB slave enums */
`default_nettype none

package fb_pkg;

    typedef logic [3:0]  cidx_t;  // palette index
    typedef logic [11:0] colr_t;  // {r, g, b} 4 bits each
    typedef logic [2:0]  scale_t;

    // last sampled bus phase
    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_e;

    // target of an access
    typedef enum logic [1:0] {
        rgn_ctrl,
        rgn_palette,
        rgn_framebuffer,
        rgn_none
    } region_e;

endpackage

`default_nettype wire

//--- hw/fb_ifs.sv
/* display and config interfaces
   raster position/sync bundle and APB-driven config bundle */
`default_nettype none
`include "fb_macros.svh"

interface disp_if;
    logic [`FB_CORDW-1:0] sx;  // horizontal position
    logic [`FB_CORDW-1:0] sy;  // vertical position
    logic de;      // active area
    logic hsync;   // active low
    logic vsync;   // active low
    logic line;    // one clock at end of active line
    logic frame;   // one clock on last blanking line

    modport timing (output sx, sy, de, hsync, vsync, line, frame);
    modport fetch  (input sx, sy, line, frame);
    modport paint  (input de, hsync, vsync);
endinterface

interface cfg_if import fb_pkg::*; ;
    logic  fb_we;  // one-clock strobe
    logic [$clog2(`FB_WIDTH * `FB_HEIGHT)-1:0] fb_addr;  // row-major word index
    cidx_t fb_data;
    logic  pal_we;  // one-clock strobe
    cidx_t pal_idx;
    colr_t pal_colr;
    scale_t scale;  // live value, fetch latches per frame

    modport regs  (output fb_we, fb_addr, fb_data, pal_we, pal_idx, pal_colr, scale);
    modport fetch (input fb_we, fb_addr, fb_data, scale);
    modport paint (input pal_we, pal_idx, pal_colr, scale);
endinterface

`default_nettype wire

//--- hw/display_timing.sv
/* display timing generator
   pixel and line counters with syncs, data enable, line and frame pulses */
`default_nettype none
`include "fb_macros.svh"

module display_timing (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    disp_if.timing    disp
);

    localparam logic [`FB_CORDW-1:0] h_act  = `FB_CORDW'(`FB_H_ACTIVE);
    localparam logic [`FB_CORDW-1:0] h_sync = `FB_CORDW'(`FB_H_ACTIVE + `FB_H_FP);
    localparam logic [`FB_CORDW-1:0] h_back = `FB_CORDW'(`FB_H_ACTIVE + `FB_H_FP + `FB_H_SYNC);
    localparam logic [`FB_CORDW-1:0] h_last = `FB_CORDW'(`FB_H_TOTAL - 1);
    localparam logic [`FB_CORDW-1:0] v_act  = `FB_CORDW'(`FB_V_ACTIVE);
    localparam logic [`FB_CORDW-1:0] v_sync = `FB_CORDW'(`FB_V_ACTIVE + `FB_V_FP);
    localparam logic [`FB_CORDW-1:0] v_back = `FB_CORDW'(`FB_V_ACTIVE + `FB_V_FP + `FB_V_SYNC);
    localparam logic [`FB_CORDW-1:0] v_last = `FB_CORDW'(`FB_V_TOTAL - 1);

    logic [`FB_CORDW-1:0] sx;
    logic [`FB_CORDW-1:0] sy;

    // raster counters, one pixel per clock
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == h_last) begin  // end of line
            sx <= '0;
            sy <= (sy == v_last) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // everything decoded straight from the counters
    always_comb begin
        disp.sx    = sx;
        disp.sy    = sy;
        disp.de    = (sx < h_act) && (sy < v_act);
        disp.hsync = !((sx >= h_sync) && (sx < h_back));  // active low
        disp.vsync = !((sy >= v_sync) && (sy < v_back));
        disp.line  = (sx == h_act);                 // every line, incl blanking
        disp.frame = (sy == v_last) && (sx == '0);  // start of last blank line
    end

endmodule

`default_nettype wire

//--- hw/fb_fetch.sv
/* framebuffer fetch
   framebuffer store, double linebuffer fill and scaled index readout */
`default_nettype none
`include "fb_macros.svh"

module fb_fetch import fb_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    disp_if.fetch     disp,
    cfg_if.fetch      cfg,
    output cidx_t     cidx,     // index for position one clock back
    output logic      in_area   // inside scaled image
);

    localparam logic [`FB_CORDW-1:0] h_last = `FB_CORDW'(`FB_H_TOTAL - 1);
    localparam logic [`FB_CORDW-1:0] v_act  = `FB_CORDW'(`FB_V_ACTIVE);
    localparam logic [`FB_CORDW-1:0] v_last = `FB_CORDW'(`FB_V_TOTAL - 1);
    localparam logic [2:0] rows   = 3'(`FB_HEIGHT);
    localparam logic [3:0] cols   = 4'(`FB_WIDTH);

    cidx_t fb_mem [`FB_WIDTH * `FB_HEIGHT];
    cidx_t lb_mem [2 * `FB_WIDTH];  // {half, col}

    scale_t scale_q;     // per-frame copy of cfg.scale
    scale_t lcnt;        // display line within source row
    scale_t rep_cnt;     // horizontal repeat
    logic [2:0] src_row; // next row to load, stops at 6
    logic [3:0] rd_col;  // sx / scale, saturating
    logic fill_busy;
    logic rd_half;       // half being displayed
    logic load_now;
    logic fill_we;
    logic [2:0] fill_col;
    logic [`FB_CORDW-1:0] next_sy;
    logic [`FB_CORDW-1:0] v_span;

    always_ff @(posedge clk_pix) begin
        if (cfg.fb_we) fb_mem[cfg.fb_addr] <= cfg.fb_data;
    end

    always_comb begin
        next_sy  = (disp.sy == v_last) ? '0 : disp.sy + 1'b1;
        load_now = disp.line && (next_sy < v_act) && (lcnt == '0) && (src_row < rows);
        fill_we  = load_now || fill_busy;  // sx 32..39, eight clocks
        fill_col = disp.sx[2:0];           // active width is a multiple of 8
        v_span   = `FB_CORDW'(scale_q * `FB_HEIGHT);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            scale_q   <= scale_t'(`FB_SCALE_MAX);
            lcnt      <= '0;
            src_row   <= '0;
            fill_busy <= 1'b0;
            rd_half   <= 1'b0;
        end else begin
            if (disp.frame) begin
                scale_q <= cfg.scale;
                lcnt    <= '0;
                src_row <= '0;
            end else if (disp.line && (next_sy < v_act)) begin
                lcnt <= (lcnt == scale_q - 3'd1) ? '0 : lcnt + 3'd1;
            end
            if (load_now) fill_busy <= 1'b1;
            if (fill_busy && (disp.sx == h_last)) begin  // swap right before sx 0
                fill_busy <= 1'b0;
                rd_half   <= ~rd_half;
                src_row   <= src_row + 3'd1;
            end
        end
    end

    // fill idle half from current source row
    always_ff @(posedge clk_pix) begin
        if (fill_we) lb_mem[{~rd_half, fill_col}] <= fb_mem[{src_row, fill_col}];
    end

    // column step every scale pixels
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            rd_col  <= '0;
            rep_cnt <= '0;
        end else if (disp.sx == h_last) begin
            rd_col  <= '0;
            rep_cnt <= '0;
        end else if (rep_cnt == scale_q - 3'd1) begin
            rep_cnt <= '0;
            if (rd_col != cols) rd_col <= rd_col + 4'd1;
        end else begin
            rep_cnt <= rep_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) in_area <= 1'b0;
        else         in_area <= (rd_col < cols) && (disp.sy < v_span);
    end

    always_ff @(posedge clk_pix) begin
        cidx <= lb_mem[{rd_half, rd_col[2:0]}];  // col 8 masked by in_area
    end

endmodule

`default_nettype wire

//--- hw/apb_regs.sv
/* APB register slave
   scale register plus write-only palette and framebuffer windows */
`default_nettype none
`include "fb_macros.svh"

module apb_regs import fb_pkg::*; (
    input  wire logic        clk_pix,
    input  wire logic        arst_n,
    input  wire logic [11:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    cfg_if.regs              cfg
);

    apb_state_e state_q;
    apb_state_e state_d;
    region_e    region;
    scale_t     scale_q;
    logic [11:0] pal_off;
    logic [11:0] fb_off;
    logic scale_ok;
    logic bad;
    logic commit;  // write on access clock

    always_comb begin
        pal_off  = paddr - `FB_ADDR_PAL;
        fb_off   = paddr - `FB_ADDR_FB;
        if (paddr == `FB_ADDR_CTRL)                                   region = rgn_ctrl;
        else if (pal_off < 12'(16 * 4) && paddr[1:0] == 2'b00)        region = rgn_palette;
        else if (fb_off < 12'(`FB_WIDTH * `FB_HEIGHT * 4) && paddr[1:0] == 2'b00)
            region = rgn_framebuffer;
        else                                                           region = rgn_none;
        scale_ok = (pwdata >= 32'd1) && (pwdata <= 32'(`FB_SCALE_MAX));
        bad = (region == rgn_none)
            || (!pwrite && region != rgn_ctrl)            // windows are write-only
            || (pwrite && region == rgn_ctrl && !scale_ok);
        state_d = !psel ? apb_idle : (penable ? apb_access : apb_setup);
        commit  = (state_q == apb_setup) && psel && penable && pwrite;

        cfg.fb_we    = commit && (region == rgn_framebuffer);
        cfg.fb_addr  = fb_off[7:2];
        cfg.fb_data  = pwdata[3:0];
        cfg.pal_we   = commit && (region == rgn_palette);
        cfg.pal_idx  = pal_off[5:2];
        cfg.pal_colr = pwdata[11:0];
        cfg.scale    = scale_q;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= apb_idle;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
            scale_q <= scale_t'(`FB_SCALE_MAX);
        end else begin
            state_q <= state_d;
            pready  <= (state_d == apb_setup);  // high through the access phase
            pslverr <= (state_d == apb_setup) && bad;
            prdata  <= (state_d == apb_setup && !pwrite && region == rgn_ctrl)
                     ? 32'(scale_q) : '0;
            if (commit && region == rgn_ctrl && scale_ok) scale_q <= pwdata[2:0];
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_paint.sv
/* pixel paint
   palette lookup, area and blanking gating, registered VGA outputs */
`default_nettype none

module pixel_paint import fb_pkg::*; (
    input  wire logic  clk_pix,
    input  wire logic  arst_n,
    disp_if.paint      disp,
    cfg_if.paint       cfg,
    input  wire cidx_t cidx,     // one clock behind timing
    input  wire logic  in_area,  // aligned with cidx
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    colr_t pal_mem [16];
    colr_t colr_q;         // lookup result, two clocks behind
    logic [1:0] hs_dly;    // timing to lookup alignment
    logic [1:0] vs_dly;
    logic [1:0] de_dly;
    logic area_q;

    // writable palette, black after reset
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) pal_mem[i] <= '0;
        end else if (cfg.pal_we) begin
            pal_mem[cfg.pal_idx] <= cfg.pal_colr;
        end
    end

    always_ff @(posedge clk_pix) begin
        colr_q <= pal_mem[cidx];
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hs_dly    <= '1;  // syncs idle high
            vs_dly    <= '1;
            de_dly    <= '0;
            area_q    <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hs_dly <= {hs_dly[0], disp.hsync};
            vs_dly <= {vs_dly[0], disp.vsync};
            de_dly <= {de_dly[0], disp.de};
            area_q <= in_area;
            vga_hsync <= hs_dly[1];
            vga_vsync <= vs_dly[1];
            // black in blanking and outside the image
            {vga_r, vga_g, vga_b} <= (de_dly[1] && area_q) ? colr_q : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/fb_scaler_top.sv
/* scaled framebuffer display engine
   APB-configured framebuffer shown through a palette with 1..4x scaling */
`default_nettype none

module fb_scaler_top (
    input  wire logic        clk_pix,
    input  wire logic        arst_n,
    // apb3 slave
    input  wire logic [11:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    // vga pins, 3 clocks behind timing
    output logic             vga_hsync,
    output logic             vga_vsync,
    output logic      [3:0]  vga_r,
    output logic      [3:0]  vga_g,
    output logic      [3:0]  vga_b
);

    disp_if disp0 ();
    cfg_if  cfg0 ();

    logic [3:0] cidx;  // fetch to paint
    logic       in_area;

    display_timing timing0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp0.timing)
    );

    fb_fetch fetch0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp0.fetch),
        .cfg     (cfg0.fetch),
        .cidx    (cidx),
        .in_area (in_area)
    );

    apb_regs regs0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg0.regs)
    );

    pixel_paint paint0 (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .disp      (disp0.paint),
        .cfg       (cfg0.paint),
        .cidx      (cidx),
        .in_area   (in_area),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
/* testbench clock and reset
   10 ns pixel clock, arst_n held low for three cycles */
`default_nettype none

module tb_clock (
    output logic clk_pix,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk_pix);
        #1 arst_n = 1'b1;  // release off the edge
    end

endmodule

`default_nettype wire

//--- tests/tb_fb_scaler.sv
/* scaled framebuffer testbench
   APB stimulus, pixel reference model and sync and colour assertions */
`default_nettype none
`include "fb_macros.svh"

module tb_fb_scaler;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int line_len  = `FB_H_TOTAL;
    localparam int frame_len = `FB_H_TOTAL * `FB_V_TOTAL;
    localparam int pulse_pos = (`FB_V_TOTAL - 1) * `FB_H_TOTAL;  // frame pulse position
    localparam int max_clks  = 8000;

    logic        clk_pix;
    logic        arst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;

    logic [11:0] pal_ref [16];  // model copies
    logic [3:0]  fb_ref [48];
    int          scale_ref;
    logic [31:0] lcg_state;

    int   mpos;        // raster position, y * line_len + x
    int   p0, p1, p2;  // p2 is what the pins show now
    int   fr_scale;    // scale of the frame at the pins
    int   chk_left;
    int   chk_n;
    logic chk_start;
    logic checking;
    logic live;
    int   cycles;

    tb_clock clk0 (.clk_pix(clk_pix), .arst_n(arst_n));

    fb_scaler_top dut0 (
        .clk_pix (clk_pix),   .arst_n (arst_n),
        .paddr   (paddr),     .psel   (psel),
        .penable (penable),   .pwrite (pwrite),
        .pwdata  (pwdata),    .prdata (prdata),
        .pready  (pready),    .pslverr (pslverr),
        .vga_hsync (vga_hsync), .vga_vsync (vga_vsync),
        .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b)
    );

    task automatic report_fail(input string msg);
        $display("Error: %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // palette of the source pixel, black outside the scaled image
    function automatic logic [11:0] expect_colr(input int x, input int y, input int s);
        if (x < `FB_H_ACTIVE && y < `FB_V_ACTIVE && x < `FB_WIDTH * s && y < `FB_HEIGHT * s)
            return pal_ref[fb_ref[(y / s) * `FB_WIDTH + x / s]];
        return 12'h000;
    endfunction

    // position model, pins lag three clocks
    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            mpos     <= 0;
            p0       <= -1;
            p1       <= -1;
            p2       <= -1;
            fr_scale <= `FB_SCALE_MAX;
            chk_left <= 0;
            checking <= 1'b0;
        end else begin
            mpos <= (mpos == frame_len - 1) ? 0 : mpos + 1;
            p0   <= mpos;
            p1   <= p0;
            p2   <= p1;
            if (mpos == pulse_pos) fr_scale <= scale_ref;  // latched with the frame pulse
            if (chk_start) begin
                chk_left <= chk_n;
            end else if (p2 == 0) begin  // frame start at the pins
                checking <= (chk_left > 0);
                if (chk_left > 0) chk_left <= chk_left - 1;
            end
        end
    end

    assign live = (p2 == 0) ? (chk_left > 0) : checking;

    always @(posedge clk_pix) begin
        if (arst_n && p2 >= 0 && live)
            assert ({vga_r, vga_g, vga_b} == expect_colr(p2 % line_len, p2 / line_len, fr_scale))
            else report_fail($sformatf("pixel (%0d,%0d) got %h expected %h",
                p2 % line_len, p2 / line_len, {vga_r, vga_g, vga_b},
                expect_colr(p2 % line_len, p2 / line_len, fr_scale)));
    end

    // sync widths and periods
    int   hs_low = 0;
    int   hs_per = 0;
    int   vs_low = 0;
    int   vs_per = 0;
    logic hs_prev = 1'b1;
    logic vs_prev = 1'b1;
    logic hs_seen = 1'b0;
    logic vs_seen = 1'b0;

    always @(posedge clk_pix) begin
        if (arst_n) begin
            hs_per++;
            vs_per++;
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            if (hs_prev && !vga_hsync) begin
                if (hs_seen) assert (hs_per == line_len)
                    else report_fail($sformatf("hsync period %0d", hs_per));
                hs_seen = 1'b1;
                hs_per  = 0;
            end
            if (!hs_prev && vga_hsync) begin
                assert (hs_low == `FB_H_SYNC)
                    else report_fail($sformatf("hsync width %0d", hs_low));
                hs_low = 0;
            end
            if (vs_prev && !vga_vsync) begin
                if (vs_seen) assert (vs_per == frame_len)
                    else report_fail($sformatf("vsync period %0d", vs_per));
                vs_seen = 1'b1;
                vs_per  = 0;
            end
            if (!vs_prev && vga_vsync) begin
                assert (vs_low == `FB_V_SYNC * line_len)
                    else report_fail($sformatf("vsync width %0d", vs_low));
                vs_low = 0;
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
        end
    end

    // run limit
    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= max_clks) begin
            $display("Run did not finish within %0d clocks", max_clks);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // one apb transfer, zero wait states expected
    task automatic apb_xfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk_pix);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        @(posedge clk_pix);
        #1;
        penable = 1'b1;
        waits   = 0;
        while (!pready) begin
            @(posedge clk_pix);
            #1;
            waits++;
        end
        assert (waits == 0)
            else report_fail($sformatf("transfer to %h took %0d waits", addr, waits));
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_pix);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(addr, 1'b1, data, rd, err);
        assert (err == exp_err) else report_fail($sformatf("write %h pslverr %b", addr, err));
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(addr, 1'b0, 32'h0, rd, err);
        assert (err == exp_err && rd == exp_data)
            else report_fail($sformatf("read %h got %h err %b", addr, rd, err));
    endtask

    // arm after the next frame pulse, return when n frames are checked
    task automatic check_frames(input int n);
        @(posedge clk_pix);
        while (mpos != pulse_pos) @(posedge clk_pix);
        #1;
        chk_n     = n;
        chk_start = 1'b1;
        @(posedge clk_pix);
        #1;
        chk_start = 1'b0;
        wait (chk_left == 0 && checking);
        wait (!checking);
    endtask

    // illegal accesses while a frame is being checked
    task automatic bad_accesses();
        apb_write(`FB_ADDR_CTRL, 32'd0, 1'b1);
        apb_write(`FB_ADDR_CTRL, 32'd5, 1'b1);
        apb_read(`FB_ADDR_PAL + 12'h8, 32'h0, 1'b1);  // write-only window
        apb_read(12'h080, 32'h0, 1'b1);               // unmapped
        apb_write(12'hffc, 32'h1, 1'b1);
        apb_write(`FB_ADDR_PAL + 12'h2, 32'h0, 1'b1);  // misaligned
        apb_read(`FB_ADDR_CTRL, 32'd4, 1'b0);
    endtask

    initial begin
        logic [31:0] r;
        int          idx;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        chk_start = 1'b0;
        chk_n     = 0;
        cycles    = 0;
        scale_ref = `FB_SCALE_MAX;
        lcg_state = 32'hfc8b_5b5e;

        #12;
        assert (vga_hsync === 1'b1 && vga_vsync === 1'b1 && {vga_r, vga_g, vga_b} === 12'h0
                && pready === 1'b0 && pslverr === 1'b0)
            else report_fail("outputs not idle during reset");
        wait (arst_n);
        repeat (2) @(posedge clk_pix);  // clocked, bus still idle
        #1;
        assert (vga_hsync === 1'b1 && vga_vsync === 1'b1 && {vga_r, vga_g, vga_b} === 12'h0
                && pready === 1'b0 && pslverr === 1'b0)
            else report_fail("outputs not idle after reset");

        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            pal_ref[i] = r[27:16];
            apb_write(`FB_ADDR_PAL + 12'(4 * i), {20'h0, pal_ref[i]}, 1'b0);
        end
        for (int i = 0; i < `FB_WIDTH * `FB_HEIGHT; i++) begin
            r = lcg_next();
            fb_ref[i] = r[23:20];
            apb_write(`FB_ADDR_FB + 12'(4 * i), {28'h0, fb_ref[i]}, 1'b0);
        end

        // default scale, two frames, error accesses inside them
        fork
            check_frames(2);
            begin
                wait (checking);
                bad_accesses();
            end
        join

        // scale 2 and one palette entry rewritten
        apb_write(`FB_ADDR_CTRL, 32'd2, 1'b0);
        scale_ref = 2;
        apb_read(`FB_ADDR_CTRL, 32'd2, 1'b0);
        idx = int'(fb_ref[0]);
        pal_ref[idx] = ~pal_ref[idx];
        apb_write(`FB_ADDR_PAL + 12'(4 * idx), {20'h0, pal_ref[idx]}, 1'b0);
        check_frames(1);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
hw/fb_pkg.sv
hw/fb_ifs.sv
hw/display_timing.sv
hw/fb_fetch.sv
hw/apb_regs.sv
hw/pixel_paint.sv
hw/fb_scaler_top.sv
tests/tb_clock.sv
tests/tb_fb_scaler.sv

//--- Makefile
# Verilator build and run for the framebuffer scaler testbench

VERILATOR ?= verilator
TOP       ?= tb_fb_scaler
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) include/fb_macros.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
